/* project.f */
src/awe_row_buffer_pkg.sv
src/pixel_ram.sv
src/row_buffer_writer.sv
src/row_buffer_reader.sv
src/awe_row_buffers.sv
test/awe_row_buffers_checker.sv
test/awe_row_buffers_tb.sv

/* Makefile */
TB_TOP := awe_row_buffers_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module awe_row_buffers

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TB_TOP)
	@out=$$(./obj_dir/V$(TB_TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir

/* test/awe_row_buffers_stimulus.txt */
# state gray pfb_rden row col num_cols pixel execute pix_seq row_matric matric_addr last_kernel
#   then expected pixel_dataout valid cycle_counter; all hex, one line per clock cycle
# Prime rows 0 to 2, then column 2 again past the limit
02 0 1 00 00 02 1000 0 00000 0 00 0  00000000 0 0
02 0 1 00 01 02 1001 0 00000 0 00 0  00000000 0 0
02 0 1 00 02 02 1002 0 00000 0 00 0  00000000 0 0
02 0 1 01 00 02 2000 0 00000 0 00 0  00000000 0 0
02 0 1 01 01 02 2001 0 00000 0 00 0  00000000 0 0
02 0 1 02 00 02 3000 0 00000 0 00 0  00000000 0 0
02 0 1 02 01 02 3001 0 00000 0 00 0  00000000 0 0
02 0 1 00 02 01 1bad 0 00000 0 00 0  00000000 0 0
# Reads with gray 00, then 01, 11 with parity, 10
08 0 0 00 00 00 0000 1 00000 0 00 0  00000000 0 0
08 0 0 00 00 00 0000 1 40000 0 00 0  00000000 0 0
08 0 0 00 00 00 0000 1 40404 0 00 0  00000000 0 0
08 0 0 00 00 00 0000 1 00808 0 00 0  10001000 1 0
08 1 0 00 00 00 0000 1 00000 0 00 0  20003000 1 1
08 3 0 00 00 00 0000 1 00402 0 00 0  20013001 1 2
08 2 0 00 00 00 0000 1 40004 0 00 0  10021002 1 3
# Row matriculation, the third one without last_kernel
08 0 0 00 00 00 4001 0 00000 1 01 0  20001000 1 4
08 0 0 00 00 00 5000 0 00000 1 00 0  20013001 1 0
08 0 0 00 00 00 6000 0 00000 1 00 0  20011000 1 1
08 0 0 00 00 00 0000 0 00000 0 00 1  00000000 0 2
08 1 0 00 00 00 0000 0 00000 0 00 1  00000000 0 2
08 3 0 00 00 00 0000 0 00000 0 00 0  00000000 0 2
# Read back after matriculation
08 0 0 00 00 00 0000 1 00004 0 00 0  00000000 0 2
08 0 0 00 00 00 0000 1 40000 0 00 0  00000000 0 2
08 0 0 00 00 00 0000 0 00000 0 00 0  00000000 0 2
08 0 0 00 00 00 0000 0 00000 0 00 0  40015000 1 2
08 0 0 00 00 00 0000 0 00000 0 00 0  20003000 1 3
08 0 0 00 00 00 0000 0 00000 0 00 0  00000000 0 4
08 0 0 00 00 00 0000 0 00000 0 00 0  00000000 0 4

/* test/awe_row_buffers_tb.sv */
`default_nettype none

module awe_row_buffers_tb
    import awe_row_buffer_pkg::*;
();

    localparam int    reset_cycles = 5;
    localparam int    field_count  = 15;
    localparam string stim_path    = "test/awe_row_buffers_stimulus.txt";

    logic                     clk;
    logic                     rst;
    awe_state_e               state;
    logic [1:0]               gray_code;
    logic                     pfb_rden;
    col_t                     input_row;
    col_t                     input_col;
    col_t                     num_input_cols;
    pixel_t                   pixel_datain;
    logic                     execute;
    pix_seq_t                 pix_seq_datain;
    logic                     row_matric;
    col_t                     row_matric_wr_addr;
    logic                     last_kernel;
    logic [2*pixel_width-1:0] pixel_dataout;
    logic                     pixel_dataout_valid;
    cycle_count_t             cycle_counter;

    // Expected outputs for the cycle being driven
    logic [2*pixel_width-1:0] exp_data;
    logic                     exp_valid;
    cycle_count_t             exp_count;
    int                       error_count;
    int                       check_count;

    logic [31:0] fields [field_count];
    int          fd;
    int          bad_lines;
    int          cycles;
    int          cycle_limit;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    awe_row_buffers #(
        .matric_delay(3)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .state              (state),
        .gray_code          (gray_code),
        .pfb_rden           (pfb_rden),
        .input_row          (input_row),
        .input_col          (input_col),
        .num_input_cols     (num_input_cols),
        .pixel_datain       (pixel_datain),
        .execute            (execute),
        .pix_seq_datain     (pix_seq_datain),
        .row_matric         (row_matric),
        .row_matric_wr_addr (row_matric_wr_addr),
        .last_kernel        (last_kernel),
        .pixel_dataout      (pixel_dataout),
        .pixel_dataout_valid(pixel_dataout_valid),
        .cycle_counter      (cycle_counter)
    );

    awe_row_buffers_checker checker_i (
        .clk                (clk),
        .pixel_dataout      (pixel_dataout),
        .pixel_dataout_valid(pixel_dataout_valid),
        .cycle_counter      (cycle_counter),
        .exp_data           (exp_data),
        .exp_valid          (exp_valid),
        .exp_count          (exp_count),
        .error_count        (error_count),
        .check_count        (check_count)
    );

    ////////////////////////////////////////
    // Stimulus file access
    ////////////////////////////////////////

    function automatic bit skip_line(input string s);
        return s.len() == 0 || s[0] == "#" || s[0] == "\n" || s[0] == "\r";
    endfunction

    // Next line that carries data, comments and blank lines skipped
    task automatic next_data_line(input int fd_in, output string s, output bit found);
        int n;
        n = $fgets(s, fd_in);
        while (n != 0 && skip_line(s)) begin
            n = $fgets(s, fd_in);
        end
        found = (n != 0);
    endtask

    task automatic count_data_lines(output int n);
        int    cfd;
        string s;
        bit    found;
        n = 0;
        cfd = $fopen(stim_path, "r");
        if (cfd != 0) begin
            next_data_line(cfd, s, found);
            while (found) begin
                n++;
                next_data_line(cfd, s, found);
            end
            $fclose(cfd);
        end
    endtask

    function automatic int parse_line(input string s);
        return $sscanf(s, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       fields[0], fields[1], fields[2], fields[3], fields[4],
                       fields[5], fields[6], fields[7], fields[8], fields[9],
                       fields[10], fields[11], fields[12], fields[13], fields[14]);
    endfunction

    ////////////////////////////////////////
    // Replay, one data line per clock
    ////////////////////////////////////////

    initial begin
        string s;
        bit    found;
        int    n_lines;

        rst                = 1'b1;
        state              = st_idle;
        gray_code          = 2'b00;
        pfb_rden           = 1'b0;
        input_row          = '0;
        input_col          = '0;
        num_input_cols     = '0;
        pixel_datain       = '0;
        execute            = 1'b0;
        pix_seq_datain     = '0;
        row_matric         = 1'b0;
        row_matric_wr_addr = '0;
        last_kernel        = 1'b0;
        exp_data           = '0;
        exp_valid          = 1'b0;
        exp_count          = '0;
        bad_lines          = 0;
        cycle_limit        = 0;

        count_data_lines(n_lines);
        fd = $fopen(stim_path, "r");
        if (fd == 0 || n_lines == 0) begin
            $display("Stimulus file %s is missing or holds no data lines", stim_path);
            $display("TEST RESULT: FAIL");
            $finish;
        end else begin
            cycle_limit = reset_cycles + n_lines + 20;
            repeat (reset_cycles) @(posedge clk);
            rst <= 1'b0;
            next_data_line(fd, s, found);
            while (found) begin
                @(posedge clk);
                if (parse_line(s) != field_count) begin
                    $display("Stimulus line could not be read: %s", s);
                    bad_lines++;
                end else begin
                    state              <= awe_state_e'(fields[0][5:0]);
                    gray_code          <= fields[1][1:0];
                    pfb_rden           <= fields[2][0];
                    input_row          <= fields[3][col_width-1:0];
                    input_col          <= fields[4][col_width-1:0];
                    num_input_cols     <= fields[5][col_width-1:0];
                    pixel_datain       <= fields[6][pixel_width-1:0];
                    execute            <= fields[7][0];
                    pix_seq_datain     <= pix_seq_t'(fields[8][18:0]);
                    row_matric         <= fields[9][0];
                    row_matric_wr_addr <= fields[10][col_width-1:0];
                    last_kernel        <= fields[11][0];
                    exp_data           <= fields[12];
                    exp_valid          <= fields[13][0];
                    exp_count          <= fields[14][2:0];
                end
                next_data_line(fd, s, found);
            end
            $fclose(fd);
            // Let the last line's check go by
            @(posedge clk);
            $display("Checked %0d cycles, %0d value errors, %0d bad stimulus lines",
                     check_count, error_count, bad_lines);
            if (error_count == 0 && bad_lines == 0) begin
                $display("TEST RESULT: PASS");
            end else begin
                $display("TEST RESULT: FAIL");
            end
            $finish;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("Timeout: stimulus replay did not end within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* test/awe_row_buffers_checker.sv */
`default_nettype none

module awe_row_buffers_checker
    import awe_row_buffer_pkg::*;
(
    input  logic                     clk,
    input  logic [2*pixel_width-1:0] pixel_dataout,
    input  logic                     pixel_dataout_valid,
    input  cycle_count_t             cycle_counter,
    input  logic [2*pixel_width-1:0] exp_data,
    input  logic                     exp_valid,
    input  cycle_count_t             exp_count,
    output int                       error_count,
    output int                       check_count
);

    int errors = 0;
    int checks = 0;

    assign error_count = errors;
    assign check_count = checks;

    ////////////////////////////////////////
    // Compare once per cycle
    ////////////////////////////////////////

    // Sample mid-cycle, away from the edge that moves the outputs
    always @(negedge clk) begin
        checks++;
        if (pixel_dataout_valid !== exp_valid) begin
            $display("Error: pixel_dataout_valid expected %h got %h at time %0t",
                     exp_valid, pixel_dataout_valid, $time);
            errors++;
        end
        if (cycle_counter !== exp_count) begin
            $display("Error: cycle_counter expected %h got %h at time %0t",
                     exp_count, cycle_counter, $time);
            errors++;
        end
        // Data only means something on a valid cycle
        if (exp_valid && (pixel_dataout !== exp_data)) begin
            $display("Error: pixel_dataout expected %h got %h at time %0t",
                     exp_data, pixel_dataout, $time);
            errors++;
        end
    end

endmodule

`default_nettype wire

/* src/awe_row_buffers.sv */
`default_nettype none

module awe_row_buffers
    import awe_row_buffer_pkg::*;
#(
    parameter int matric_delay = 3
) (
    input  logic                   clk,
    input  logic                   rst,
    input  awe_state_e             state,
    input  logic [1:0]             gray_code,
    input  logic                   pfb_rden,
    input  col_t                   input_row,
    input  col_t                   input_col,
    input  col_t                   num_input_cols,
    input  pixel_t                 pixel_datain,
    input  logic                   execute,
    input  pix_seq_t               pix_seq_datain,
    input  logic                   row_matric,
    input  col_t                   row_matric_wr_addr,
    input  logic                   last_kernel,
    // Odd bank upper, even bank lower
    output logic [2*pixel_width-1:0] pixel_dataout,
    output logic                   pixel_dataout_valid,
    output cycle_count_t           cycle_counter
);

    logic      even_wren;
    ram_addr_t even_wr_addr;
    pixel_t    even_wr_data;
    logic      odd_wren;
    ram_addr_t odd_wr_addr;
    pixel_t    odd_wr_data;
    logic      even_rden;
    logic      odd_rden;
    ram_addr_t even_rd_addr;
    ram_addr_t odd_rd_addr;

    row_buffer_writer #(
        .matric_delay(matric_delay)
    ) writer_i (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .gray_code         (gray_code),
        .pfb_rden          (pfb_rden),
        .input_row         (input_row),
        .input_col         (input_col),
        .num_input_cols    (num_input_cols),
        .pixel_datain      (pixel_datain),
        .row_matric        (row_matric),
        .row_matric_wr_addr(row_matric_wr_addr),
        .last_kernel       (last_kernel),
        .even_wren         (even_wren),
        .even_wr_addr      (even_wr_addr),
        .even_wr_data      (even_wr_data),
        .odd_wren          (odd_wren),
        .odd_wr_addr       (odd_wr_addr),
        .odd_wr_data       (odd_wr_data)
    );

    row_buffer_reader #(
        .valid_delay(ram_read_latency)
    ) reader_i (
        .clk                (clk),
        .rst                (rst),
        .state              (state),
        .gray_code          (gray_code),
        .execute            (execute),
        .pix_seq_datain     (pix_seq_datain),
        .even_rden          (even_rden),
        .odd_rden           (odd_rden),
        .even_rd_addr       (even_rd_addr),
        .odd_rd_addr        (odd_rd_addr),
        .pixel_dataout_valid(pixel_dataout_valid),
        .cycle_counter      (cycle_counter)
    );

    ////////////////////////////////////////
    // Banks
    ////////////////////////////////////////

    pixel_ram even_ram_i (
        .clk    (clk),
        .wren   (even_wren),
        .wr_addr(even_wr_addr),
        .wr_data(even_wr_data),
        .rden   (even_rden),
        .rd_addr(even_rd_addr),
        .rd_data(pixel_dataout[pixel_width-1:0])
    );

    pixel_ram odd_ram_i (
        .clk    (clk),
        .wren   (odd_wren),
        .wr_addr(odd_wr_addr),
        .wr_data(odd_wr_data),
        .rden   (odd_rden),
        .rd_addr(odd_rd_addr),
        .rd_data(pixel_dataout[2*pixel_width-1:pixel_width])
    );

endmodule

`default_nettype wire

/* src/row_buffer_reader.sv */
`default_nettype none

module row_buffer_reader
    import awe_row_buffer_pkg::*;
#(
    parameter int valid_delay = ram_read_latency
) (
    input  logic         clk,
    input  logic         rst,
    input  awe_state_e   state,
    input  logic [1:0]   gray_code,
    input  logic         execute,
    input  pix_seq_t     pix_seq_datain,
    output logic         even_rden,
    output logic         odd_rden,
    output ram_addr_t    even_rd_addr,
    output ram_addr_t    odd_rd_addr,
    output logic         pixel_dataout_valid,
    output cycle_count_t cycle_counter
);

    logic                   rd_strobe;
    logic                   rd_go;
    ram_addr_t              even_addr_dec;
    ram_addr_t              odd_addr_dec;
    logic [valid_delay-1:0] valid_pipe;

    ////////////////////////////////////////
    // Sequence word decode
    ////////////////////////////////////////

    // Gray bits flip the half select per bank
    assign even_addr_dec = {gray_code[1] ^ pix_seq_datain.half_sel, pix_seq_datain.even_col};
    assign odd_addr_dec  = {gray_code[0] ^ pix_seq_datain.half_sel,
                            pix_seq_datain.odd_col_hi,
                            pix_seq_datain.odd_col_lsb | pix_seq_datain.parity};

    assign rd_go = (state == st_ce_active) && execute;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_strobe <= 1'b0;
        end else begin
            rd_strobe <= rd_go;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_go) begin
            even_rd_addr <= even_addr_dec;
            odd_rd_addr  <= odd_addr_dec;
        end
    end

    // Both banks read together
    assign even_rden = rd_strobe;
    assign odd_rden  = rd_strobe;

    ////////////////////////////////////////
    // Valid and cycle count
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe    <= '0;
            cycle_counter <= '0;
        end else begin
            valid_pipe[0] <= rd_strobe;
            for (int i = 1; i < valid_delay; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
            if (pixel_dataout_valid) begin
                if (cycle_counter == cycle_count_t'(cycles_per_output - 1)) begin
                    cycle_counter <= '0;
                end else begin
                    cycle_counter <= cycle_counter + 3'd1;
                end
            end
        end
    end

    assign pixel_dataout_valid = valid_pipe[valid_delay-1];

    counter_in_range: assert property (@(posedge clk) disable iff (rst)
        cycle_counter < cycle_count_t'(cycles_per_output));
    valid_follows_read: assert property (@(posedge clk) disable iff (rst)
        $rose(pixel_dataout_valid) |-> $past(rd_strobe, valid_delay));

endmodule

`default_nettype wire

/* src/row_buffer_writer.sv */
`default_nettype none

module row_buffer_writer
    import awe_row_buffer_pkg::*;
#(
    parameter int matric_delay = 3
) (
    input  logic       clk,
    input  logic       rst,
    input  awe_state_e state,
    input  logic [1:0] gray_code,
    input  logic       pfb_rden,
    input  col_t       input_row,
    input  col_t       input_col,
    input  col_t       num_input_cols,
    input  pixel_t     pixel_datain,
    input  logic       row_matric,
    input  col_t       row_matric_wr_addr,
    input  logic       last_kernel,
    output logic       even_wren,
    output ram_addr_t  even_wr_addr,
    output pixel_t     even_wr_data,
    output logic       odd_wren,
    output ram_addr_t  odd_wr_addr,
    output pixel_t     odd_wr_data
);

    logic [matric_delay-1:0] matric_pipe;
    col_t                    matric_addr_pipe [matric_delay];
    pixel_t                  matric_data_pipe [matric_delay];

    logic      prime_ok;
    logic      matric_hit;
    logic      even_wren_nxt;
    logic      odd_wren_nxt;
    ram_addr_t even_addr_nxt;
    ram_addr_t odd_addr_nxt;
    pixel_t    even_data_nxt;
    pixel_t    odd_data_nxt;

    ////////////////////////////////////////
    // Matriculation delay line
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            matric_pipe <= '0;
        end else begin
            matric_pipe[0] <= row_matric;
            for (int i = 1; i < matric_delay; i++) begin
                matric_pipe[i] <= matric_pipe[i-1];
            end
        end
    end

    // Address and pixel ride along with the strobe
    always_ff @(posedge clk) begin
        matric_addr_pipe[0] <= row_matric_wr_addr;
        matric_data_pipe[0] <= pixel_datain;
        for (int i = 1; i < matric_delay; i++) begin
            matric_addr_pipe[i] <= matric_addr_pipe[i-1];
            matric_data_pipe[i] <= matric_data_pipe[i-1];
        end
    end

    ////////////////////////////////////////
    // Next write per bank
    ////////////////////////////////////////

    assign prime_ok   = (state == st_prime_buffer) && pfb_rden
                        && (input_col <= num_input_cols);
    assign matric_hit = matric_pipe[matric_delay-1] && last_kernel;

    always_comb begin
        even_wren_nxt = 1'b0;
        odd_wren_nxt  = 1'b0;
        even_addr_nxt = {1'b0, input_col};
        odd_addr_nxt  = {1'b0, input_col};
        even_data_nxt = pixel_datain;
        odd_data_nxt  = pixel_datain;

        // Priming, three rows over the two banks
        if (prime_ok) begin
            if (input_row == col_t'(0)) begin
                even_wren_nxt = 1'b1;
                odd_wren_nxt  = 1'b1;
            end else if (input_row == col_t'(1)) begin
                odd_wren_nxt  = 1'b1;
                odd_addr_nxt  = {1'b1, input_col};
            end else if (input_row == col_t'(2)) begin
                even_wren_nxt = 1'b1;
                even_addr_nxt = {1'b1, input_col};
            end
        end

        // Incoming row, wins over priming on the same bank
        if (matric_hit) begin
            if (gray_code[0] == gray_code[1]) begin
                odd_wren_nxt  = 1'b1;
                odd_addr_nxt  = {gray_code[0], matric_addr_pipe[matric_delay-1]};
                odd_data_nxt  = matric_data_pipe[matric_delay-1];
            end else begin
                even_wren_nxt = 1'b1;
                even_addr_nxt = {gray_code[1], matric_addr_pipe[matric_delay-1]};
                even_data_nxt = matric_data_pipe[matric_delay-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            even_wren <= 1'b0;
            odd_wren  <= 1'b0;
        end else begin
            even_wren <= even_wren_nxt;
            odd_wren  <= odd_wren_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (even_wren_nxt) begin
            even_wr_addr <= even_addr_nxt;
            even_wr_data <= even_data_nxt;
        end
        if (odd_wren_nxt) begin
            odd_wr_addr <= odd_addr_nxt;
            odd_wr_data <= odd_data_nxt;
        end
    end

    // A strobed write must carry a known address into the RAM
    even_addr_known: assert property (@(posedge clk) disable iff (rst)
        even_wren |-> !$isunknown(even_wr_addr));
    odd_addr_known: assert property (@(posedge clk) disable iff (rst)
        odd_wren |-> !$isunknown(odd_wr_addr));

endmodule

`default_nettype wire

/* src/pixel_ram.sv */
`default_nettype none

module pixel_ram
    import awe_row_buffer_pkg::*;
(
    input  logic      clk,
    input  logic      wren,
    input  ram_addr_t wr_addr,
    input  pixel_t    wr_data,
    input  logic      rden,
    input  ram_addr_t rd_addr,
    output pixel_t    rd_data
);

    pixel_t mem [bram_depth];
    pixel_t rd_q;
    logic   rden_q;

    always_ff @(posedge clk) begin
        if (wren) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Array read stage
    always_ff @(posedge clk) begin
        rden_q <= rden;
        if (rden) begin
            rd_q <= mem[rd_addr];
        end
    end

    // Output stage follows the read it belongs to, holds otherwise
    always_ff @(posedge clk) begin
        if (rden_q) begin
            rd_data <= rd_q;
        end
    end

endmodule

`default_nettype wire

/* src/awe_row_buffer_pkg.sv */
`default_nettype none

package awe_row_buffer_pkg;

    ////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////

    localparam int pixel_width = 16;
    localparam int bram_depth  = 512;
    localparam int addr_width  = $clog2(bram_depth);
    // Top address bit picks the bank half
    localparam int col_width   = addr_width - 1;

    localparam int cycles_per_output = 5;
    // Read strobe to data, array register plus output register
    localparam int ram_read_latency  = 2;

    ////////////////////////////////////////
    // Types
    ////////////////////////////////////////

    typedef logic [pixel_width-1:0] pixel_t;
    typedef logic [addr_width-1:0]  ram_addr_t;
    typedef logic [col_width-1:0]   col_t;
    typedef logic [2:0]             cycle_count_t;

    // Window engine state, one-hot
    typedef enum logic [5:0] {
        st_idle          = 6'b000001,
        st_prime_buffer  = 6'b000010,
        st_wait_pfb_load = 6'b000100,
        st_ce_active     = 6'b001000,
        st_wait_job_done = 6'b010000,
        st_send_complete = 6'b100000
    } awe_state_e;

    // Pixel-sequence word, 19 bits, top field first
    typedef struct packed {
        logic                 half_sel;
        logic [col_width-1:0] even_col;
        logic [col_width-2:0] odd_col_hi;
        logic                 odd_col_lsb;
        logic                 parity;
        logic                 spare;
    } pix_seq_t;

endpackage

`default_nettype wire
